/* include/acl_rx_defines.svh */
// ACL receive buffer sizes, data widths and the APB register map
`ifndef ACL_RX_DEFINES_SVH
`define ACL_RX_DEFINES_SVH

// one ACL payload per bank, up to 1023 bytes
`define ACL_BUF_DEPTH 256
`define ACL_BUF_AW 8

// buffer word and APB data width
`define ACL_WORD_W 32

// payload length counted in bytes
`define ACL_LEN_W 10

// host side, byte addressed
`define ACL_APB_AW 11

// data window occupies 0x000..0x3fc, status sits right above it
`define ACL_REG_STATUS 11'h400

// status word fields
`define ACL_STAT_FLOW_BIT 0
`define ACL_STAT_LEN_LSB 16

`endif

/* rtl/acl_rx_pkg.sv */
// shared types for the ACL receive path
// widths come from the defines header
`include "acl_rx_defines.svh"

package acl_rx_pkg;

  // word address into one 256x32 bank
  typedef logic [`ACL_BUF_AW-1:0] buf_addr_t;

  // one stored buffer word, bytes little-endian
  typedef logic [`ACL_WORD_W-1:0] acl_word_t;

  // payload length in bytes
  // saturates at 1023 in the packer
  typedef logic [`ACL_LEN_W-1:0] pylen_t;

  // host byte address
  typedef logic [`ACL_APB_AW-1:0] apb_addr_t;

  // apb reader sequencing
  // idle      decode in setup phase
  // wait_sram first access cycle of a window read
  // done      completing access cycle
  typedef enum logic [1:0] {
    idle,
    wait_sram,
    done
  } rd_state_t;

endpackage

/* rtl/acl_wr_if.sv */
// write path bundle from the byte packer to the buffer control
`timescale 1ns/1ps

interface acl_wr_if
  import acl_rx_pkg::*;
();

  // word address inside the current write bank
  buf_addr_t wr_addr;

  // packed word, zero filled when flushed early
  acl_word_t wr_data;

  // one cycle per word, never stalled
  logic      wr_en;

  // running byte count of the payload
  pylen_t    byte_cnt;

  // packer side
  modport src (
    output wr_addr,
    output wr_data,
    output wr_en,
    output byte_cnt
  );

  // buffer control side
  modport ctrl (
    input  wr_addr,
    input  wr_data,
    input  wr_en,
    input  byte_cnt
  );

endinterface

/* rtl/acl_rd_if.sv */
// host read bundle between the APB reader and the buffer control
`timescale 1ns/1ps

interface acl_rd_if
  import acl_rx_pkg::*;
();

  // word address in the read bank
  buf_addr_t rd_addr;

  // sram select, data follows one cycle later
  logic      rd_cs;

  // completing cycle of the last word read, frees the bank
  logic      rd_last_p;

  // read bank data and its latched length
  acl_word_t rd_data;
  pylen_t    rd_len;

  // apb reader side
  modport src (
    output rd_addr,
    output rd_cs,
    output rd_last_p,
    input  rd_data,
    input  rd_len
  );

  // buffer control side
  modport ctrl (
    input  rd_addr,
    input  rd_cs,
    input  rd_last_p,
    output rd_data,
    output rd_len
  );

endinterface

/* rtl/sram256x32_1p.sv */
// behavioral single-port synchronous sram, 256x32
// registered read, one cycle latency
`timescale 1ns/1ps
`include "acl_rx_defines.svh"

module sram256x32_1p
  import acl_rx_pkg::*;
(
  input  logic      clk_6M,
  input  buf_addr_t a,
  input  acl_word_t din,
  input  logic      we,
  input  logic      cs,
  output acl_word_t dout
);

  acl_word_t mem [`ACL_BUF_DEPTH];

  // write when selected with we, else read
  // dout holds its value while deselected
  always_ff @(posedge clk_6M)
  begin
    if (cs)
    begin
      if (we)
        mem[a] <= din;
      else
        dout <= mem[a];
    end
  end

endmodule

/* rtl/acl_payload_packer.sv */
// byte to word packer for decoded ACL payload bytes
// little-endian lanes, word address and payload byte counter
`timescale 1ns/1ps

module acl_payload_packer (
  input  logic       clk_6M,
  input  logic       rstz,
  input  logic [7:0] dec_byte,
  input  logic       dec_byte_valid,
  input  logic       payload_start_p,
  input  logic       ms_tslot_p,
  acl_wr_if.src      wr
);

  // next byte lane within the word being assembled
  logic [1:0]  lane_q;

  // lanes 0..2 of the pending word
  // lane 3 goes straight into wr_data
  logic [23:0] word_q;

  logic        byte_acc;
  logic        word_full;
  logic        flush_p;

  // decoder has finished the payload by the slot boundary
  assign byte_acc  = dec_byte_valid & ~payload_start_p;
  assign word_full = byte_acc & (lane_q == 2'd3);

  // partial word left at slot end
  assign flush_p = ms_tslot_p & ~payload_start_p & ~dec_byte_valid & (lane_q != 2'd0);

  // control: lane count, write strobe, address, byte count
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      lane_q      <= 2'd0;
      wr.wr_en    <= 1'b0;
      wr.wr_addr  <= '0;
      wr.byte_cnt <= '0;
    end
    else
    begin
      // strobe lasts one cycle
      wr.wr_en <= word_full | flush_p;

      if (payload_start_p)
      begin
        lane_q      <= 2'd0;
        wr.byte_cnt <= '0;
      end
      else if (byte_acc)
      begin
        // wraps 3 -> 0 at word end
        lane_q <= lane_q + 2'd1;
        // saturate at 1023
        if (wr.byte_cnt != '1)
          wr.byte_cnt <= wr.byte_cnt + 1'b1;
      end
      else if (flush_p)
        lane_q <= 2'd0;

      // step to the next word once the current one is written
      if (payload_start_p)
        wr.wr_addr <= '0;
      else if (wr.wr_en)
        wr.wr_addr <= wr.wr_addr + 1'b1;
    end
  end

  // payload: lane assembly and outgoing word
  always_ff @(posedge clk_6M)
  begin
    if (payload_start_p)
      word_q <= '0;
    else if (word_full)
    begin
      // fourth byte completes the word
      wr.wr_data <= {dec_byte, word_q};
      word_q     <= '0;
    end
    else if (byte_acc)
      word_q[{lane_q, 3'b000} +: 8] <= dec_byte;
    else if (flush_p)
    begin
      // unused lanes already zero
      wr.wr_data <= {8'h00, word_q};
      word_q     <= '0;
    end
  end

endmodule

/* rtl/acl_rxbuf_ctrl.sv */
// ping-pong receive buffer control with two 256x32 banks
// commit and free rules, per-bank lengths, destination flow bit
`timescale 1ns/1ps

module acl_rxbuf_ctrl
  import acl_rx_pkg::*;
(
  input  logic   clk_6M,
  input  logic   rstz,
  input  logic   corre_trgp,
  input  logic   connsactive,
  input  logic   ckheader_endp,
  input  logic   lt_addressed,
  input  logic   pktype_data,
  input  logic   pk_encode,
  input  logic   dec_hecgood,
  input  logic   dec_crcgood,
  input  logic   ms_tslot_p,
  input  logic   tx_packet_st_p,
  acl_wr_if.ctrl wr,
  acl_rd_if.ctrl rd,
  output logic   aclrxbuf_empty
);

  // bank taking packer writes, the other one serves the host
  logic       wr_bank;
  logic       rd_bank;
  logic [1:0] full_q;
  pylen_t     len_q [2];
  logic       rxindicator;

  logic       rx_ok;
  logic       wr_open;
  logic       commit_p;
  logic       free_p;
  logic       flow_upd_p;

  buf_addr_t  sram_a [2];
  logic [1:0] sram_we;
  logic [1:0] sram_cs;
  acl_word_t  sram_dout [2];

  assign rd_bank = ~wr_bank;

  // header and payload both decoded clean, not encrypted
  assign rx_ok   = ~pk_encode & dec_hecgood & dec_crcgood;
  assign wr_open = ~full_q[wr_bank];

  assign commit_p   = tx_packet_st_p & rx_ok & pktype_data & rxindicator & wr_open;
  // ignore last-word reads on a bank that holds nothing
  assign free_p     = rd.rd_last_p & full_q[rd_bank];
  assign flow_upd_p = ckheader_endp & rx_ok & pktype_data & rxindicator & lt_addressed;

  // set on our own correlator hit, cleared when we start to transmit
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      rxindicator <= 1'b0;
    else if (corre_trgp & connsactive)
      rxindicator <= 1'b1;
    else if (tx_packet_st_p)
      rxindicator <= 1'b0;
  end

  // bank fill state and latched lengths
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      full_q   <= 2'b00;
      len_q[0] <= '0;
      len_q[1] <= '0;
    end
    else
    begin
      if (ms_tslot_p & rx_ok & wr_open)
        len_q[wr_bank] <= wr.byte_cnt;
      if (commit_p)
        full_q[wr_bank] <= 1'b1;
      if (free_p)
        full_q[rd_bank] <= 1'b0;
    end
  end

  // swap when the committed bank has an empty partner,
  // or when the host frees a bank while the write bank waits full
  // commit and free together count as one swap
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      wr_bank <= 1'b0;
    else if ((commit_p & (~full_q[rd_bank] | free_p)) | (free_p & full_q[wr_bank]))
      wr_bank <= ~wr_bank;
  end

  // flow bit only moves after a header, never mid payload
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      aclrxbuf_empty <= 1'b1;
    else if (flow_upd_p)
      aclrxbuf_empty <= wr_open;
  end

  // per bank port steering
  // writes dropped while the write bank is full
  for (genvar b = 0; b < 2; b++)
  begin : g_bank
    logic is_wr;

    assign is_wr      = (wr_bank == b);
    assign sram_a[b]  = is_wr ? wr.wr_addr : rd.rd_addr;
    assign sram_we[b] = is_wr & wr.wr_en & ~full_q[b];
    assign sram_cs[b] = is_wr ? sram_we[b] : rd.rd_cs;

    sram256x32_1p u_sram (
      .clk_6M (clk_6M),
      .a      (sram_a[b]),
      .din    (wr.wr_data),
      .we     (sram_we[b]),
      .cs     (sram_cs[b]),
      .dout   (sram_dout[b])
    );
  end

  // host view of the read bank
  // empty bank reports length 0
  assign rd.rd_data = sram_dout[rd_bank];
  assign rd.rd_len  = full_q[rd_bank] ? len_q[rd_bank] : '0;

endmodule

/* rtl/acl_rx_apb_reader.sv */
// APB slave for the ACL receive buffer
// data window read, status register, error response
`timescale 1ns/1ps
`include "acl_rx_defines.svh"

module acl_rx_apb_reader
  import acl_rx_pkg::*;
(
  input  logic      clk_6M,
  input  logic      rstz,
  input  logic      psel,
  input  logic      penable,
  input  logic      pwrite,
  input  apb_addr_t paddr,
  // write data has no destination, writes only raise pslverr
  input  acl_word_t pwdata,
  output acl_word_t prdata,
  output logic      pready,
  output logic      pslverr,
  input  logic      aclrxbuf_empty,
  acl_rd_if.src     rd
);

  rd_state_t                state;
  logic                     setup_p;
  logic                     win_rd;
  logic                     bad_acc;
  logic [`ACL_LEN_W:0]      len_rnd;
  logic [`ACL_BUF_AW:0]     last_word;
  logic                     last_hit;
  acl_word_t                status_word;

  assign setup_p = psel & ~penable;
  assign win_rd  = ~pwrite & (paddr < `ACL_REG_STATUS);
  assign bad_acc = pwrite | (paddr > `ACL_REG_STATUS);

  // byte address to word index
  assign rd.rd_addr = paddr[`ACL_BUF_AW+1:2];

  // sram read issued during setup, data lands in the first access cycle
  assign rd.rd_cs = (state == idle) & setup_p & win_rd;

  // last word = ceil(len/4) - 1, all ones for len 0 so nothing matches
  assign len_rnd   = {1'b0, rd.rd_len} + 3'd3;
  assign last_word = len_rnd[`ACL_LEN_W:2] - 1'b1;
  assign last_hit  = ({1'b0, rd.rd_addr} >= last_word);

  // flow bit in bit 0, read bank length in 25:16
  always_comb
  begin
    status_word = '0;
    status_word[`ACL_STAT_FLOW_BIT] = aclrxbuf_empty;
    status_word[`ACL_STAT_LEN_LSB +: `ACL_LEN_W] = rd.rd_len;
  end

  // window read: setup, access with pready low, access with pready high
  // status and errors: setup, one access with pready high
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      state        <= idle;
      pready       <= 1'b0;
      pslverr      <= 1'b0;
      rd.rd_last_p <= 1'b0;
    end
    else
    begin
      case (state)
        idle:
        begin
          if (setup_p)
          begin
            if (win_rd)
              state <= wait_sram;
            else
            begin
              state   <= done;
              pready  <= 1'b1;
              pslverr <= bad_acc;
            end
          end
        end
        wait_sram:
        begin
          state        <= done;
          pready       <= 1'b1;
          pslverr      <= 1'b0;
          rd.rd_last_p <= last_hit;
        end
        done:
        begin
          state        <= idle;
          pready       <= 1'b0;
          pslverr      <= 1'b0;
          rd.rd_last_p <= 1'b0;
        end
        default:
          state <= idle;
      endcase
    end
  end

  // read data capture
  // error responses return zero
  always_ff @(posedge clk_6M)
  begin
    if ((state == idle) & setup_p & ~win_rd)
      prdata <= bad_acc ? '0 : status_word;
    else if (state == wait_sram)
      prdata <= rd.rd_data;
  end

endmodule

/* rtl/acl_rx_top.sv */
// ACL receive subsystem top level
// packer -> ping-pong buffer control -> APB reader
`timescale 1ns/1ps

module acl_rx_top
  import acl_rx_pkg::*;
(
  input  logic       clk_6M,
  input  logic       rstz,
  // decoded payload bytes
  input  logic [7:0] dec_byte,
  input  logic       dec_byte_valid,
  input  logic       payload_start_p,
  // decoder and slot events
  input  logic       corre_trgp,
  input  logic       connsactive,
  input  logic       ckheader_endp,
  input  logic       lt_addressed,
  input  logic       pktype_data,
  input  logic       pk_encode,
  input  logic       dec_hecgood,
  input  logic       dec_crcgood,
  input  logic       ms_tslot_p,
  input  logic       tx_packet_st_p,
  // host apb
  input  logic       psel,
  input  logic       penable,
  input  logic       pwrite,
  input  apb_addr_t  paddr,
  input  acl_word_t  pwdata,
  output acl_word_t  prdata,
  output logic       pready,
  output logic       pslverr,
  // destination flow, 1 when a buffer can take a packet
  output logic       aclrxbuf_empty
);

  acl_wr_if wr_if ();
  acl_rd_if rd_if ();

  acl_payload_packer u_packer (
    .clk_6M          (clk_6M),
    .rstz            (rstz),
    .dec_byte        (dec_byte),
    .dec_byte_valid  (dec_byte_valid),
    .payload_start_p (payload_start_p),
    .ms_tslot_p      (ms_tslot_p),
    .wr              (wr_if.src)
  );

  acl_rxbuf_ctrl u_bufctrl (
    .clk_6M         (clk_6M),
    .rstz           (rstz),
    .corre_trgp     (corre_trgp),
    .connsactive    (connsactive),
    .ckheader_endp  (ckheader_endp),
    .lt_addressed   (lt_addressed),
    .pktype_data    (pktype_data),
    .pk_encode      (pk_encode),
    .dec_hecgood    (dec_hecgood),
    .dec_crcgood    (dec_crcgood),
    .ms_tslot_p     (ms_tslot_p),
    .tx_packet_st_p (tx_packet_st_p),
    .wr             (wr_if.ctrl),
    .rd             (rd_if.ctrl),
    .aclrxbuf_empty (aclrxbuf_empty)
  );

  acl_rx_apb_reader u_apb (
    .clk_6M         (clk_6M),
    .rstz           (rstz),
    .psel           (psel),
    .penable        (penable),
    .pwrite         (pwrite),
    .paddr          (paddr),
    .pwdata         (pwdata),
    .prdata         (prdata),
    .pready         (pready),
    .pslverr        (pslverr),
    .aclrxbuf_empty (aclrxbuf_empty),
    .rd             (rd_if.src)
  );

endmodule

/* verif/acl_rx_tb.sv */
// directed testbench for the ACL receive subsystem
// two-bank scoreboard, LFSR payload bytes, cycle watchdog
`timescale 1ns/1ps
`include "acl_rx_defines.svh"

module acl_rx_tb
  import acl_rx_pkg::*;
();

  // one packet plus its events, a window word read, a short access
  localparam int pkt_cycles  = 1023 + 12;
  localparam int word_cycles = 5;
  localparam int max_cycles  = 9 * pkt_cycles + 4 * 256 * word_cycles + 60 * word_cycles + 300;

  logic       clk_6M;
  logic       rstz;
  logic [7:0] dec_byte;
  logic       dec_byte_valid;
  logic       payload_start_p;
  logic       corre_trgp;
  logic       connsactive;
  logic       ckheader_endp;
  logic       lt_addressed;
  logic       pktype_data;
  logic       pk_encode;
  logic       dec_hecgood;
  logic       dec_crcgood;
  logic       ms_tslot_p;
  logic       tx_packet_st_p;
  logic       psel;
  logic       penable;
  logic       pwrite;
  apb_addr_t  paddr;
  acl_word_t  pwdata;
  acl_word_t  prdata;
  logic       pready;
  logic       pslverr;
  logic       aclrxbuf_empty;

  // scoreboard: two banks with fill flags, lengths and stored bytes
  logic       m_wr_bank;
  logic       m_full [2];
  pylen_t     m_len [2];
  logic       m_flow;
  logic [7:0] bank_mem [2][1024];

  logic [19:0] lfsr_q;
  int          word_errs;
  int          len_errs;
  int          bit_errs;
  int          cycle_cnt;

  acl_rx_top acl_rx_top_i (.*);

  initial
  begin
    clk_6M = 1'b0;
  end

  always #10 clk_6M = ~clk_6M;

  // watchdog
  always @(posedge clk_6M)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == max_cycles)
    begin
      $display("timeout: run exceeded %0d cycles without finishing", max_cycles);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  // x^20 + x^17 + 1, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_q = {lfsr_q[18:0], lfsr_q[19] ^ lfsr_q[16]};
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  task automatic check_word(input string name, input acl_word_t exp, input acl_word_t act);
    if (exp !== act)
    begin
      $display("ERR %s expected %h actual %h", name, exp, act);
      word_errs++;
    end
  endtask

  task automatic check_len(input string name, input pylen_t exp, input pylen_t act);
    if (exp !== act)
    begin
      $display("ERR %s expected %0d actual %0d", name, exp, act);
      len_errs++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (exp !== act)
    begin
      $display("ERR %s expected %b actual %b", name, exp, act);
      bit_errs++;
    end
  endtask

  // setup, then access until pready, sampled on the falling edge
  task automatic apb_read(input apb_addr_t addr, input logic write,
                          output acl_word_t data, output logic err);
    @(posedge clk_6M);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= write;
    paddr   <= addr;
    pwdata  <= 32'hdead_beef;
    @(posedge clk_6M);
    penable <= 1'b1;
    @(negedge clk_6M);
    while (!pready)
      @(negedge clk_6M);
    data = prdata;
    err  = pslverr;
    @(posedge clk_6M);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  // status fields against the scoreboard
  task automatic check_status(input string name);
    acl_word_t d;
    logic      e;
    int        rb;
    rb = !m_wr_bank;
    apb_read(`ACL_REG_STATUS, 1'b0, d, e);
    check_bit({name, " status pslverr"}, 1'b0, e);
    check_bit({name, " flow"}, m_flow, d[`ACL_STAT_FLOW_BIT]);
    check_len({name, " length"}, m_full[rb] ? m_len[rb] : pylen_t'(0),
              d[`ACL_STAT_LEN_LSB +: `ACL_LEN_W]);
  endtask

  // header, payload bytes, slot end, then tx start
  task automatic send_packet(input pylen_t len, input logic crc_good, input logic enc,
                             input logic is_data);
    logic       rx_ok;
    logic       take;
    logic [7:0] b;
    int         wb;
    rx_ok = crc_good & !enc;
    wb    = m_wr_bank;
    take  = rx_ok & is_data & !m_full[wb];
    @(posedge clk_6M);
    dec_crcgood <= crc_good;
    pk_encode   <= enc;
    pktype_data <= is_data;
    corre_trgp  <= 1'b1;
    @(posedge clk_6M);
    corre_trgp    <= 1'b0;
    ckheader_endp <= 1'b1;
    // flow bit follows the write bank at the header
    if (rx_ok & is_data)
      m_flow = !m_full[wb];
    @(posedge clk_6M);
    ckheader_endp   <= 1'b0;
    payload_start_p <= 1'b1;
    @(posedge clk_6M);
    payload_start_p <= 1'b0;
    for (int i = 0; i < len; i++)
    begin
      b = rand_bits(8);
      if (take)
        bank_mem[wb][i] = b;
      dec_byte       <= b;
      dec_byte_valid <= 1'b1;
      @(posedge clk_6M);
    end
    dec_byte_valid <= 1'b0;
    ms_tslot_p     <= 1'b1;
    @(posedge clk_6M);
    ms_tslot_p <= 1'b0;
    // let the flushed word land before commit
    repeat (3) @(posedge clk_6M);
    tx_packet_st_p <= 1'b1;
    @(posedge clk_6M);
    tx_packet_st_p <= 1'b0;
    if (take)
    begin
      m_full[wb] = 1'b1;
      m_len[wb]  = len;
      if (!m_full[!wb])
        m_wr_bank = !m_wr_bank;
    end
    @(posedge clk_6M);
  endtask

  // read every word of the read bank, the last one frees it
  task automatic drain_bank(input string name);
    acl_word_t d;
    acl_word_t exp;
    logic      e;
    int        rb;
    int        n;
    int        idx;
    rb = !m_wr_bank;
    n  = (int'(m_len[rb]) + 3) / 4;
    for (int w = 0; w < n; w++)
    begin
      exp = '0;
      for (int k = 0; k < 4; k++)
      begin
        idx = 4 * w + k;
        if (idx < m_len[rb])
          exp[8*k +: 8] = bank_mem[rb][idx];
      end
      apb_read(apb_addr_t'(4 * w), 1'b0, d, e);
      check_word({name, " window word"}, exp, d);
      check_bit({name, " window pslverr"}, 1'b0, e);
    end
    m_full[rb] = 1'b0;
    if (m_full[m_wr_bank])
      m_wr_bank = !m_wr_bank;
    check_status({name, " after drain"});
  endtask

  function automatic pylen_t pick_len();
    pylen_t l;
    l = pylen_t'(rand_bits(10));
    return (l == 0) ? pylen_t'(1) : l;
  endfunction

  task automatic reset_state_test();
    check_bit("t1 pready idle", 1'b0, pready);
    check_status("t1");
  endtask

  task automatic single_packet_test();
    send_packet(pick_len(), 1'b1, 1'b0, 1'b1);
    check_status("t2");
    drain_bank("t2");
  endtask

  task automatic rejected_packet_test();
    send_packet(pick_len(), 1'b0, 1'b0, 1'b1);
    check_status("t3 bad crc");
    send_packet(pick_len(), 1'b1, 1'b1, 1'b1);
    check_status("t3 encoded");
    send_packet(pick_len(), 1'b1, 1'b0, 1'b0);
    check_status("t3 not data");
  endtask

  // fill both banks, drop a third, then free one and refill
  task automatic both_banks_test();
    send_packet(pick_len(), 1'b1, 1'b0, 1'b1);
    send_packet(pick_len(), 1'b1, 1'b0, 1'b1);
    check_status("t4 two full");
    send_packet(pick_len(), 1'b1, 1'b0, 1'b1);
    // flow output pin, held since the dropped packet's header
    @(negedge clk_6M);
    check_bit("t4 flow when full", 1'b0, aclrxbuf_empty);
    check_status("t4 dropped");
    drain_bank("t4 first");
    send_packet(pick_len(), 1'b1, 1'b0, 1'b1);
    check_status("t4 refill");
    drain_bank("t4 second");
  endtask

  // leaves the buffer state alone, then the last packet drains intact
  task automatic bad_access_test();
    acl_word_t d;
    logic      e;
    apb_read(11'h000, 1'b1, d, e);
    check_bit("t5 write pslverr", 1'b1, e);
    apb_read(11'h404, 1'b0, d, e);
    check_bit("t5 high read pslverr", 1'b1, e);
    check_word("t5 high read data", '0, d);
    check_status("t5");
    drain_bank("t5");
  endtask

  initial
  begin
    lfsr_q    = 20'd94410;
    word_errs = 0;
    len_errs  = 0;
    bit_errs  = 0;
    cycle_cnt = 0;
    m_wr_bank = 1'b0;
    m_full    = '{1'b0, 1'b0};
    m_len     = '{'0, '0};
    m_flow    = 1'b1;
    rstz            <= 1'b0;
    dec_byte        <= '0;
    dec_byte_valid  <= 1'b0;
    payload_start_p <= 1'b0;
    corre_trgp      <= 1'b0;
    connsactive     <= 1'b1;
    ckheader_endp   <= 1'b0;
    lt_addressed    <= 1'b1;
    pktype_data     <= 1'b0;
    pk_encode       <= 1'b0;
    dec_hecgood     <= 1'b1;
    dec_crcgood     <= 1'b0;
    ms_tslot_p      <= 1'b0;
    tx_packet_st_p  <= 1'b0;
    psel            <= 1'b0;
    penable         <= 1'b0;
    pwrite          <= 1'b0;
    paddr           <= '0;
    pwdata          <= '0;
    repeat (10) @(posedge clk_6M);
    rstz <= 1'b1;
    @(posedge clk_6M);

    reset_state_test();
    single_packet_test();
    rejected_packet_test();
    both_banks_test();
    send_packet(pick_len(), 1'b1, 1'b0, 1'b1);
    bad_access_test();

    $display("errors: word %0d, length %0d, bit %0d", word_errs, len_errs, bit_errs);
    if (word_errs + len_errs + bit_errs == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

/* filelist.f */
+incdir+include
rtl/acl_rx_pkg.sv
rtl/acl_wr_if.sv
rtl/acl_rd_if.sv
rtl/sram256x32_1p.sv
rtl/acl_payload_packer.sv
rtl/acl_rxbuf_ctrl.sv
rtl/acl_rx_apb_reader.sv
rtl/acl_rx_top.sv
verif/acl_rx_tb.sv

/* run_sim.sh */
#!/bin/sh
# compile the ACL receive testbench with Verilator, run it, and check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal -f filelist.f --top-module acl_rx_tb \
  -o acl_rx_sim && ./obj_dir/acl_rx_sim | tee sim.log

grep -q "SIMULATION PASSED" sim.log && echo "run ok" || {
  echo "run failed, see sim.log"
  exit 1
}
